// File: capchk_consts.svh
`ifndef CAPCHK_CONSTS_SVH
`define CAPCHK_CONSTS_SVH

// Field widths
`define CAPCHK_EXP_W   5
`define CAPCHK_BND_W   7
`define CAPCHK_ADDR_W  40
`define CAPCHK_WIN_W   8

// Field positions inside the 64-bit pointer
`define CAPCHK_EXP_HI  63
`define CAPCHK_EXP_LO  59
`define CAPCHK_HI_HI   58
`define CAPCHK_HI_LO   52
`define CAPCHK_LOW_HI  51
`define CAPCHK_LOW_LO  45
`define CAPCHK_ONLOW   44
`define CAPCHK_ADDR_HI 43
`define CAPCHK_ADDR_LO 4

`endif

// File: capchk_pkg.sv
`include "capchk_consts.svh"

package capchk_pkg;

  // Same bit order as the raw pointer, exp at the top
  typedef struct packed {
    logic [`CAPCHK_EXP_W-1:0]  exp;
    logic [`CAPCHK_BND_W-1:0]  hi;
    logic [`CAPCHK_BND_W-1:0]  low;
    logic                      on_low;
    logic [`CAPCHK_ADDR_W-1:0] addr;
    logic [`CAPCHK_ADDR_LO-1:0] pad;    // Unused low bits
  } cap_t;

  typedef enum logic [1:0] {
    RES_OK    = 2'd0,
    RES_BOUND = 2'd1,
    RES_CARRY = 2'd2
  } result_e;

endpackage

// File: capchk_if.sv
`timescale 1ns/1ns
`include "capchk_consts.svh"

interface capchk_if (
  input logic clk
);

  capchk_pkg::cap_t            cap;       // Captured pointer
  logic [`CAPCHK_ADDR_W-1:0]   offset;
  logic [`CAPCHK_ADDR_W-1:0]   sum;       // addr + offset, mod 2^40
  logic                        upper_ok;
  logic                        range_ok;
  logic                        hold;      // Controller is in HOLD

  modport ctrl (
    output cap,
    output offset,
    output hold,
    input  sum,
    input  upper_ok,
    input  range_ok
  );

  modport upper (
    input  cap,
    input  offset,
    output sum,
    output upper_ok
  );

  modport range (
    input  clk,
    input  cap,
    input  sum,
    input  hold,
    output range_ok
  );

endinterface

// File: capchk_window.sv
`timescale 1ns/1ns
`include "capchk_consts.svh"

module capchk_window (
  input  logic [`CAPCHK_ADDR_W-1:0] addr,
  input  logic [`CAPCHK_EXP_W-1:0]  exp,
  output logic [`CAPCHK_WIN_W-1:0]  win
);

  logic [`CAPCHK_ADDR_W-1:0] shifted;

  // Log shifter, one stage per exponent bit
  always_comb
  begin
    shifted = addr;
    for (int i = 0; i < `CAPCHK_EXP_W; i++)
    begin
      if (exp[i])
        shifted = shifted >> (1 << i);   // Zeros shift in from bit 39
    end
  end

  assign win = shifted[`CAPCHK_WIN_W-1:0];

endmodule

// File: capchk_range.sv
`timescale 1ns/1ns
`include "capchk_consts.svh"

module capchk_range (
  capchk_if.range dp
);

  logic [`CAPCHK_WIN_W-1:0] win;
  logic [`CAPCHK_WIN_W-1:0] low8;
  logic [`CAPCHK_WIN_W-1:0] high8;
  logic                     wrap;
  logic                     lo_pass;
  logic                     hi_pass;

  capchk_window i_window (
    .addr (dp.sum),
    .exp  (dp.cap.exp),
    .win  (win)
  );

  assign low8  = {dp.cap.low, 1'b0};
  assign high8 = {dp.cap.hi, 1'b1};
  assign wrap  = dp.cap.hi < dp.cap.low;

  // A wrapped window drops one side of the compare, picked by on_low
  assign lo_pass = (win >= low8) || (wrap && !dp.cap.on_low);
  assign hi_pass = (win <= high8) || (wrap && dp.cap.on_low);

  assign dp.range_ok = lo_pass && hi_pass;

  // Operands are held stable through HOLD
  a_range_known: assert property (@(posedge dp.clk)
    dp.hold |-> !$isunknown(dp.range_ok));

endmodule

// File: capchk_upper.sv
`timescale 1ns/1ns
`include "capchk_consts.svh"

module capchk_upper (
  capchk_if.upper dp
);

  localparam int unsigned SHIFT_W = `CAPCHK_EXP_W + 1;

  logic [SHIFT_W-1:0]        top_bit;    // exp + 8
  logic [`CAPCHK_ADDR_W-1:0] mask;
  logic [`CAPCHK_ADDR_W-1:0] changed;

  assign dp.sum = dp.cap.addr + dp.offset;   // Wraps at 2^40

  assign top_bit = SHIFT_W'(dp.cap.exp) + SHIFT_W'(`CAPCHK_WIN_W);

  // Bits at exp+8 and above
  assign mask = {`CAPCHK_ADDR_W{1'b1}} << top_bit;

  assign changed = dp.sum ^ dp.cap.addr;

  assign dp.upper_ok = (changed & mask) == '0;

endmodule

// File: capchk_ctrl.sv
`timescale 1ns/1ns
`include "capchk_consts.svh"

module capchk_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req,
  output logic                      ack,
  input  logic [63:0]               ptr,
  input  logic [`CAPCHK_ADDR_W-1:0] offset,
  output capchk_pkg::result_e       result,
  output logic [`CAPCHK_ADDR_W-1:0] new_addr,
  capchk_if.ctrl                    dp
);

  typedef enum logic [1:0] {
    IDLE,
    EVAL,
    HOLD
  } state_e;

  state_e              state;
  state_e              state_nxt;
  capchk_pkg::result_e verdict;

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (req)
          state_nxt = EVAL;
      EVAL:
        state_nxt = HOLD;
      HOLD:
        if (!req)
          state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_comb
  begin
    if (!dp.upper_ok)
      verdict = capchk_pkg::RES_CARRY;   // Carry outranks bounds
    else if (!dp.range_ok)
      verdict = capchk_pkg::RES_BOUND;
    else
      verdict = capchk_pkg::RES_OK;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state  <= IDLE;
      ack    <= 1'b0;
      result <= capchk_pkg::RES_OK;
    end
    else
    begin
      state <= state_nxt;
      ack   <= (state_nxt == HOLD);
      if (state == EVAL)
        result <= verdict;
    end
  end

  // Operand capture on the edge that sees req in IDLE
  always_ff @(posedge clk)
  begin
    if (state == IDLE && req)
    begin
      dp.cap.exp    <= ptr[`CAPCHK_EXP_HI:`CAPCHK_EXP_LO];
      dp.cap.hi     <= ptr[`CAPCHK_HI_HI:`CAPCHK_HI_LO];
      dp.cap.low    <= ptr[`CAPCHK_LOW_HI:`CAPCHK_LOW_LO];
      dp.cap.on_low <= ptr[`CAPCHK_ONLOW];
      dp.cap.addr   <= ptr[`CAPCHK_ADDR_HI:`CAPCHK_ADDR_LO];
      dp.cap.pad    <= ptr[`CAPCHK_ADDR_LO-1:0];
      dp.offset     <= offset;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == EVAL)
      new_addr <= dp.sum;
  end

  assign dp.hold = (state == HOLD);

  // Host must keep req up until it has seen ack
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req));

  a_result_legal: assert property (@(posedge clk) disable iff (!rst_n)
    result inside {capchk_pkg::RES_OK, capchk_pkg::RES_BOUND, capchk_pkg::RES_CARRY});

endmodule

// File: capchk_top.sv
`timescale 1ns/1ns
`include "capchk_consts.svh"

module capchk_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req,
  input  logic [63:0]               ptr,
  input  logic [`CAPCHK_ADDR_W-1:0] offset,
  output logic                      ack,
  output logic [1:0]                result,
  output logic [`CAPCHK_ADDR_W-1:0] new_addr
);

  capchk_pkg::result_e res;

  capchk_if i_dp (
    .clk (clk)
  );

  capchk_ctrl i_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .ptr      (ptr),
    .offset   (offset),
    .result   (res),
    .new_addr (new_addr),
    .dp       (i_dp.ctrl)
  );

  capchk_upper i_upper (
    .dp (i_dp.upper)
  );

  capchk_range i_range (
    .dp (i_dp.range)
  );

  assign result = res;   // Enum out as raw bits

endmodule

// File: capchk_tb.sv
`timescale 1ns/1ns
`include "capchk_consts.svh"

module capchk_tb;

  localparam int NUM_DIR  = 17;
  localparam int NUM_RAND = 23;
  localparam int NUM_ROWS = NUM_DIR + NUM_RAND;
  localparam int WAIT_MAX = 20;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic [63:0] ptr;
  logic [39:0] offset;
  logic        ack;
  logic [1:0]  result;
  logic [39:0] new_addr;

  string       tbl_name [NUM_ROWS];
  logic [63:0] tbl_ptr  [NUM_ROWS];
  logic [39:0] tbl_off  [NUM_ROWS];
  logic [1:0]  tbl_res  [NUM_ROWS];
  logic [39:0] tbl_addr [NUM_ROWS];

  int          n_rows;
  int          n_checks;
  int          n_errors;
  int          n_timeouts;
  logic [31:0] lfsr;

  capchk_top i_capchk_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ptr      (ptr),
    .offset   (offset),
    .ack      (ack),
    .result   (result),
    .new_addr (new_addr)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    n_checks++;
    if (expected !== actual)
    begin
      n_errors++;
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32,22,2,1
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  function automatic logic [63:0] make_ptr(input logic [4:0] e, input logic [6:0] hi,
                                           input logic [6:0] low, input logic on_low,
                                           input logic [39:0] addr);
    return {e, hi, low, on_low, addr, 4'h0};
  endfunction

  // Expected result and new address from the window, range and upper rules
  task automatic ref_check(input logic [63:0] p, input logic [39:0] off,
                           output logic [1:0] res, output logic [39:0] sum);
    logic [4:0]  e;
    logic [39:0] addr;
    logic [7:0]  win;
    logic [7:0]  low8;
    logic [7:0]  high8;
    logic        wrap;
    logic        on_low;
    logic        lo_pass;
    logic        hi_pass;
    logic        upper_pass;
    int unsigned top;
    e = p[`CAPCHK_EXP_HI:`CAPCHK_EXP_LO];
    addr = p[`CAPCHK_ADDR_HI:`CAPCHK_ADDR_LO];
    on_low = p[`CAPCHK_ONLOW];
    sum = addr + off;
    win = 8'(sum >> e);
    low8 = {p[`CAPCHK_LOW_HI:`CAPCHK_LOW_LO], 1'b0};
    high8 = {p[`CAPCHK_HI_HI:`CAPCHK_HI_LO], 1'b1};
    wrap = p[`CAPCHK_HI_HI:`CAPCHK_HI_LO] < p[`CAPCHK_LOW_HI:`CAPCHK_LOW_LO];
    lo_pass = (win >= low8) || (wrap && !on_low);
    hi_pass = (win <= high8) || (wrap && on_low);
    top = e + 8;
    upper_pass = (sum >> top) == (addr >> top);
    if (!upper_pass)
      res = capchk_pkg::RES_CARRY;
    else if (!(lo_pass && hi_pass))
      res = capchk_pkg::RES_BOUND;
    else
      res = capchk_pkg::RES_OK;
  endtask

  task automatic add_row(input string name, input logic [63:0] p, input logic [39:0] off);
    logic [1:0]  res;
    logic [39:0] sum;
    ref_check(p, off, res, sum);
    tbl_name[n_rows] = name;
    tbl_ptr[n_rows] = p;
    tbl_off[n_rows] = off;
    tbl_res[n_rows] = res;
    tbl_addr[n_rows] = sum;
    n_rows++;
  endtask

  // Directed rows also carry the intended verdict as a cross-check on the model
  task automatic add_directed(input string name, input logic [63:0] p,
                              input logic [39:0] off, input capchk_pkg::result_e want);
    add_row(name, p, off);
    check_eq({name, " table"}, 64'(want), 64'(tbl_res[n_rows-1]));
  endtask

  task automatic build_table();
    logic [63:0] pa;
    logic [63:0] pw1;
    logic [63:0] pw0;
    logic [63:0] pe8;
    logic [63:0] pt;
    logic [63:0] p;
    logic [63:0] bits;
    logic [39:0] off;
    pa = make_ptr(5'd0, 7'h40, 7'h10, 1'b0, 40'h00_1234_5630);   // low8 20, high8 81
    pw1 = make_ptr(5'd0, 7'h10, 7'h60, 1'b1, 40'h00_1234_56d0);  // Wrapped with on_low set
    pw0 = make_ptr(5'd0, 7'h10, 7'h60, 1'b0, 40'h00_1234_5610);
    pe8 = make_ptr(5'd8, 7'h7f, 7'h00, 1'b0, 40'h00_0001_ff00);  // Full window
    pt = make_ptr(5'd31, 7'h7f, 7'h00, 1'b0, 40'hff_ffff_ff00);
    add_directed("ok_small", pa, 40'h10, capchk_pkg::RES_OK);
    add_directed("at_low8", pa, 40'hff_ffff_fff0, capchk_pkg::RES_OK);
    add_directed("below_low8", pa, 40'hff_ffff_ffef, capchk_pkg::RES_BOUND);
    add_directed("at_high8", pa, 40'h51, capchk_pkg::RES_OK);
    add_directed("above_high8", pa, 40'h52, capchk_pkg::RES_BOUND);
    add_directed("wrap_on_low_ok", pw1, 40'h0, capchk_pkg::RES_OK);
    add_directed("wrap_on_low_at_low8", pw1, 40'hff_ffff_fff0, capchk_pkg::RES_OK);
    add_directed("wrap_on_low_below", pw1, 40'hff_ffff_ffef, capchk_pkg::RES_BOUND);
    add_directed("wrap_on_low_top", pw1, 40'h2f, capchk_pkg::RES_OK);
    add_directed("wrap_at_high8", pw0, 40'h11, capchk_pkg::RES_OK);
    add_directed("wrap_above_high8", pw0, 40'h12, capchk_pkg::RES_BOUND);
    add_directed("wrap_bottom", pw0, 40'hff_ffff_fff0, capchk_pkg::RES_OK);
    add_directed("wrap_mid", pw0, 40'he0, capchk_pkg::RES_BOUND);
    add_directed("carry_and_bound", pa, 40'hd0, capchk_pkg::RES_CARRY);
    add_directed("exp8_no_carry", pe8, 40'hff, capchk_pkg::RES_OK);
    add_directed("exp8_carry", pe8, 40'h100, capchk_pkg::RES_CARRY);
    add_directed("carry_bit39", pt, 40'h100, capchk_pkg::RES_CARRY);
    for (int r = 0; r < NUM_RAND; r++)
    begin
      take_bits(64, p);
      take_bits(3, bits);
      p[`CAPCHK_EXP_HI:`CAPCHK_EXP_LO] = 5'(bits);   // Small exp so offsets reach the window
      take_bits(10, bits);
      off = 40'(bits);
      take_bits(1, bits);
      if (bits[0])
        off = -off;
      add_row($sformatf("random_%0d", r), p, off);
    end
  endtask

  task automatic wait_ack(input logic level, output int edges);
    edges = 0;
    while (ack !== level && edges < WAIT_MAX)
    begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (ack !== level)
    begin
      n_timeouts++;
      $display("Timeout: ack did not reach %0d within %0d clock edges", level, WAIT_MAX);
    end
  endtask

  task automatic run_row(input int idx);
    int          edges;
    int          hold_cycles;
    logic [63:0] bits;
    string       name;
    name = tbl_name[idx];
    @(posedge clk);
    #2;
    ptr = tbl_ptr[idx];
    offset = tbl_off[idx];
    req = 1'b1;
    wait_ack(1'b1, edges);
    if (n_timeouts != 0)
      return;
    check_eq({name, " ack latency"}, 64'd2, 64'(edges));
    check_eq({name, " result"}, 64'(tbl_res[idx]), 64'(result));
    check_eq({name, " new_addr"}, 64'(tbl_addr[idx]), 64'(new_addr));
    take_bits(2, bits);
    hold_cycles = int'(bits) + 1;
    #1;
    ptr = ~tbl_ptr[idx];   // Operands are free to change once ack is up
    offset = ~tbl_off[idx];
    for (int c = 0; c < hold_cycles; c++)
    begin
      @(posedge clk);
      #1;
      check_eq({name, " ack held"}, 64'd1, 64'(ack));
      check_eq({name, " result held"}, 64'(tbl_res[idx]), 64'(result));
      check_eq({name, " new_addr held"}, 64'(tbl_addr[idx]), 64'(new_addr));
    end
    #1;
    req = 1'b0;
    wait_ack(1'b0, edges);
    if (n_timeouts == 0)
      check_eq({name, " ack release"}, 64'd1, 64'(edges));
  endtask

  initial
  begin
    rst_n = 1'b0;
    req = 1'b0;
    ptr = '0;
    offset = '0;
    n_rows = 0;
    n_checks = 0;
    n_errors = 0;
    n_timeouts = 0;
    lfsr = 32'hbeae_2465;
    build_table();
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int c = 0; c < 3; c++)
    begin
      @(posedge clk);
      #1;
      check_eq("idle ack", 64'd0, 64'(ack));
      check_eq("idle result", 64'(capchk_pkg::RES_OK), 64'(result));
    end
    for (int i = 0; i < n_rows && n_timeouts == 0; i++)
      run_row(i);
    $display("rows=%0d checks=%0d errors=%0d timeouts=%0d",
             n_rows, n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: capchk_top.f
+incdir+.
capchk_pkg.sv
capchk_if.sv
capchk_window.sv
capchk_range.sv
capchk_upper.sv
capchk_ctrl.sv
capchk_top.sv
capchk_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := capchk_tb
FILELIST  := capchk_top.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then \
	  echo "test: failure found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
